// File: oled_init_settings.svh
`ifndef OLED_INIT_SETTINGS_SVH
`define OLED_INIT_SETTINGS_SVH

// i2c data path
`define OLED_BYTE_W 8
// ssd1306 write address, sa0 low
`define OLED_SLAVE_ADDR 8'h78
// co=0 d/c#=0, everything after is a command
`define OLED_CTRL_BYTE 8'h00

// command count of each init phase
`define OLED_PHASE1_LEN 15
`define OLED_PHASE2_LEN 2
`define OLED_PHASE3_LEN 1
// byte index, 0 is the control byte
`define OLED_IDX_W 5

// delays in clk cycles, simulation sized
// at 100 MHz the panel wants 5_000_000 (50 ms)
`define OLED_POWER_ON_CYCLES 40
// 1_000_000 (10 ms) after the display setup
`define OLED_GAP1_CYCLES 12
// 10_000_000 (100 ms) for the charge pump to settle
`define OLED_GAP2_CYCLES 30
// wide enough for the 100 ms count
`define OLED_DELAY_W 27

// nacks retried before giving up
`define OLED_RETRY_MAX 3

`endif

// File: oled_init_pkg.sv
`include "oled_init_settings.svh"

package oled_init_pkg;

    // command phase, also selects the rom slice
    typedef enum logic [1:0] {
        phase_1,
        phase_2,
        phase_3
    } phase_t;

    // which delay the timer counts
    typedef enum logic [1:0] {
        dly_power_on,
        dly_gap1,
        dly_gap2
    } delay_sel_t;

    // phase level fsm
    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_power_wait,
        ctrl_phase,
        ctrl_gap,
        ctrl_ready,
        ctrl_error
    } ctrl_state_t;

    // one i2c transaction
    typedef enum logic [2:0] {
        seq_idle,
        seq_req,
        seq_addr,
        seq_byte,
        seq_stop
    } seq_state_t;

    // command toward the byte master
    typedef struct packed {
        logic                   start;
        logic                   stop;
        logic                   write;
        logic [`OLED_BYTE_W-1:0] data;
    } i2c_cmd_t;

    // answer from the master, ack_err valid with done
    typedef struct packed {
        logic done;
        logic ack_err;
    } i2c_rsp_t;

    typedef struct packed {
        logic busy;
        logic init_done;
        logic err;
    } init_status_t;

endpackage

// File: init_cmd_rom.sv
`include "oled_init_settings.svh"

module init_cmd_rom (
    input  oled_init_pkg::phase_t        phase,
    input  logic [`OLED_IDX_W-1:0]       cmd_index,
    output logic [`OLED_BYTE_W-1:0]      cmd_byte,
    output logic                         last_byte
);
    import oled_init_pkg::*;

    localparam int table_len = `OLED_PHASE1_LEN + `OLED_PHASE2_LEN + `OLED_PHASE3_LEN;
    localparam logic [`OLED_IDX_W-1:0] p1_len = `OLED_PHASE1_LEN;
    localparam logic [`OLED_IDX_W-1:0] p2_len = `OLED_PHASE2_LEN;
    localparam logic [`OLED_IDX_W-1:0] p3_len = `OLED_PHASE3_LEN;

    // all three phases back to back
    localparam logic [`OLED_BYTE_W-1:0] cmd_table [table_len] = '{
        // phase 1: mux ratio, offset, start line, remap, com pins, contrast, clock
        8'hA8, 8'h3F, 8'hD3, 8'h00, 8'h40, 8'hA1, 8'hC8, 8'hDA,
        8'h12, 8'h81, 8'h7F, 8'hA4, 8'hA6, 8'hD5, 8'h80,
        // phase 2: charge pump on
        8'h8D, 8'h14,
        // phase 3: display on
        8'hAF
    };

    logic [`OLED_IDX_W-1:0] base;
    logic [`OLED_IDX_W-1:0] len;
    logic [`OLED_IDX_W-1:0] rom_addr;

    always_comb begin
        // slice of the table for this phase
        case (phase)
            phase_1: begin
                base = '0;
                len  = p1_len;
            end
            phase_2: begin
                base = p1_len;
                len  = p2_len;
            end
            default: begin
                base = p1_len + p2_len;
                len  = p3_len;
            end
        endcase
        // index 1 is the first command of the slice
        rom_addr  = base + cmd_index - 1'b1;
        last_byte = (cmd_index == len);
        if (cmd_index == '0) begin
            cmd_byte = `OLED_CTRL_BYTE;
        end else if (int'(rom_addr) < table_len) begin
            cmd_byte = cmd_table[rom_addr];
        end else begin
            cmd_byte = '0;
        end
    end

endmodule

// File: init_delay_timer.sv
`include "oled_init_settings.svh"

module init_delay_timer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         delay_go,
    input  oled_init_pkg::delay_sel_t    delay_sel,
    output logic                         delay_expired
);
    import oled_init_pkg::*;

    localparam logic [`OLED_DELAY_W-1:0] power_on_cycles = `OLED_POWER_ON_CYCLES;
    localparam logic [`OLED_DELAY_W-1:0] gap1_cycles     = `OLED_GAP1_CYCLES;
    localparam logic [`OLED_DELAY_W-1:0] gap2_cycles     = `OLED_GAP2_CYCLES;

    logic [`OLED_DELAY_W-1:0] sel_len;
    logic [`OLED_DELAY_W-1:0] count;
    logic                     running;

    always_comb begin
        case (delay_sel)
            dly_gap1: sel_len = gap1_cycles;
            dly_gap2: sel_len = gap2_cycles;
            default:  sel_len = power_on_cycles;
        endcase
    end

    // loaded with n-1, so zero is reached n cycles after go
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
        end else if (delay_go) begin
            count   <= sel_len - 1'b1;
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // single pulse on the last count
    assign delay_expired = running && (count == '0);

endmodule

// File: i2c_txn_sequencer.sv
`include "oled_init_settings.svh"

module i2c_txn_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         seq_go,
    input  logic                         oled_granted,
    input  oled_init_pkg::i2c_rsp_t      i2c_rsp,
    input  logic [`OLED_BYTE_W-1:0]      cmd_byte,
    input  logic                         last_byte,
    output logic                         oled_req,
    output oled_init_pkg::i2c_cmd_t      i2c_cmd,
    output logic [`OLED_IDX_W-1:0]       cmd_index,
    output logic                         seq_ok,
    output logic                         seq_fail
);
    import oled_init_pkg::*;

    localparam int nack_w = $clog2(`OLED_RETRY_MAX + 1);
    localparam logic [nack_w-1:0] retry_max = `OLED_RETRY_MAX;

    seq_state_t        state;
    logic [nack_w-1:0] nack_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= seq_idle;
            cmd_index <= '0;
            nack_cnt  <= '0;
            seq_ok    <= 1'b0;
            seq_fail  <= 1'b0;
        end else begin
            // result pulses last one cycle
            seq_ok   <= 1'b0;
            seq_fail <= 1'b0;
            case (state)
                seq_idle: begin
                    if (seq_go) begin
                        state     <= seq_req;
                        cmd_index <= '0;
                        nack_cnt  <= '0;
                    end
                end
                seq_req: begin
                    // hold the request until the arbiter answers
                    if (oled_granted) begin
                        state <= seq_addr;
                    end
                end
                seq_addr, seq_byte: begin
                    if (i2c_rsp.done) begin
                        if (i2c_rsp.ack_err) begin
                            // nack on any byte restarts the whole phase
                            cmd_index <= '0;
                            if (nack_cnt < retry_max) begin
                                nack_cnt <= nack_cnt + 1'b1;
                                state    <= seq_req;
                            end else begin
                                nack_cnt <= '0;
                                seq_fail <= 1'b1;
                                state    <= seq_idle;
                            end
                        end else begin
                            // any ack breaks the nack run
                            nack_cnt <= '0;
                            if (state == seq_addr) begin
                                state <= seq_byte;
                            end else if (last_byte) begin
                                state <= seq_stop;
                            end else begin
                                cmd_index <= cmd_index + 1'b1;
                            end
                        end
                    end
                end
                seq_stop: begin
                    if (i2c_rsp.done) begin
                        cmd_index <= '0;
                        seq_ok    <= 1'b1;
                        state     <= seq_idle;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // command decoded from state, held until done
    // next command may follow right in the cycle after done
    always_comb begin
        oled_req = (state == seq_req);
        i2c_cmd  = '0;
        case (state)
            seq_addr: begin
                i2c_cmd.start = 1'b1;
                i2c_cmd.write = 1'b1;
                i2c_cmd.data  = `OLED_SLAVE_ADDR;
            end
            seq_byte: begin
                // control byte at index 0, then the phase commands
                i2c_cmd.write = 1'b1;
                i2c_cmd.data  = cmd_byte;
            end
            seq_stop: begin
                i2c_cmd.stop = 1'b1;
            end
            default: begin
                i2c_cmd = '0;
            end
        endcase
    end

endmodule

// File: init_phase_ctrl.sv
module init_phase_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         seq_ok,
    input  logic                         seq_fail,
    input  logic                         delay_expired,
    output oled_init_pkg::phase_t        phase,
    output logic                         seq_go,
    output logic                         delay_go,
    output oled_init_pkg::delay_sel_t    delay_sel,
    output oled_init_pkg::init_status_t  status
);
    import oled_init_pkg::*;

    ctrl_state_t state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= ctrl_idle;
            phase            <= phase_1;
            seq_go           <= 1'b0;
            delay_go         <= 1'b0;
            delay_sel        <= dly_power_on;
            status.busy      <= 1'b1;
            status.init_done <= 1'b0;
            status.err       <= 1'b0;
        end else begin
            // go strobes are single cycle
            seq_go   <= 1'b0;
            delay_go <= 1'b0;
            case (state)
                ctrl_idle: begin
                    // start counting the supply ramp
                    delay_go  <= 1'b1;
                    delay_sel <= dly_power_on;
                    state     <= ctrl_power_wait;
                end
                ctrl_power_wait: begin
                    if (delay_expired) begin
                        phase  <= phase_1;
                        seq_go <= 1'b1;
                        state  <= ctrl_phase;
                    end
                end
                ctrl_phase: begin
                    if (seq_fail) begin
                        state       <= ctrl_error;
                        status.busy <= 1'b0;
                        status.err  <= 1'b1;
                    end else if (seq_ok) begin
                        if (phase == phase_3) begin
                            state            <= ctrl_ready;
                            status.busy      <= 1'b0;
                            status.init_done <= 1'b1;
                        end else begin
                            // gap length depends on the phase just sent
                            delay_go <= 1'b1;
                            if (phase == phase_1) begin
                                delay_sel <= dly_gap1;
                            end else begin
                                delay_sel <= dly_gap2;
                            end
                            state <= ctrl_gap;
                        end
                    end
                end
                ctrl_gap: begin
                    if (delay_expired) begin
                        // step to the following phase
                        if (phase == phase_1) begin
                            phase <= phase_2;
                        end else begin
                            phase <= phase_3;
                        end
                        seq_go <= 1'b1;
                        state  <= ctrl_phase;
                    end
                end
                ctrl_ready, ctrl_error: begin
                    // final, only reset leaves
                    state <= state;
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

endmodule

// File: oled_init_top.sv
`include "oled_init_settings.svh"

module oled_init_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         oled_granted,
    input  oled_init_pkg::i2c_rsp_t      i2c_rsp,
    output logic                         oled_req,
    output oled_init_pkg::i2c_cmd_t      i2c_cmd,
    output oled_init_pkg::init_status_t  status
);
    import oled_init_pkg::*;

    // controller to sequencer and timer
    phase_t     phase;
    delay_sel_t delay_sel;
    logic       seq_go;
    logic       seq_ok;
    logic       seq_fail;
    logic       delay_go;
    logic       delay_expired;

    // sequencer to rom
    logic [`OLED_IDX_W-1:0]  cmd_index;
    logic [`OLED_BYTE_W-1:0] cmd_byte;
    logic                    last_byte;

    init_phase_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .seq_ok        (seq_ok),
        .seq_fail      (seq_fail),
        .delay_expired (delay_expired),
        .phase         (phase),
        .seq_go        (seq_go),
        .delay_go      (delay_go),
        .delay_sel     (delay_sel),
        .status        (status)
    );

    i2c_txn_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .seq_go       (seq_go),
        .oled_granted (oled_granted),
        .i2c_rsp      (i2c_rsp),
        .cmd_byte     (cmd_byte),
        .last_byte    (last_byte),
        .oled_req     (oled_req),
        .i2c_cmd      (i2c_cmd),
        .cmd_index    (cmd_index),
        .seq_ok       (seq_ok),
        .seq_fail     (seq_fail)
    );

    init_delay_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .delay_go      (delay_go),
        .delay_sel     (delay_sel),
        .delay_expired (delay_expired)
    );

    init_cmd_rom u_rom (
        .phase     (phase),
        .cmd_index (cmd_index),
        .cmd_byte  (cmd_byte),
        .last_byte (last_byte)
    );

endmodule

// File: tb_i2c_master_model.sv
module tb_i2c_master_model (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         oled_req,
    input  oled_init_pkg::i2c_cmd_t      i2c_cmd,
    input  logic [63:0]                  nack_set,
    output logic                         oled_granted,
    output oled_init_pkg::i2c_rsp_t      i2c_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    import oled_init_pkg::*;

    integer seed;
    // writes seen since reset, first write is 1
    integer write_ord;
    logic   give_nack;

    // 1 to max_cycles edges, then settle past the edge
    task automatic wait_random_latency(input integer max_cycles);
        integer n;
        n = 1 + (($random(seed) & 32'h7fff_ffff) % max_cycles);
        repeat (n) @(posedge clk);
        #5;
    endtask

    initial begin
        seed         = 32'hfa0d;
        write_ord    = 0;
        give_nack    = 1'b0;
        oled_granted = 1'b0;
        i2c_rsp      = '0;
        forever begin
            @(posedge clk);
            #5;
            if (reset) begin
                write_ord    = 0;
                oled_granted = 1'b0;
                i2c_rsp      = '0;
            end else if (oled_req) begin
                // arbiter side, one cycle grant
                wait_random_latency(3);
                oled_granted = 1'b1;
                @(posedge clk);
                #5;
                oled_granted = 1'b0;
            end else if (i2c_cmd.write || i2c_cmd.stop) begin
                give_nack = 1'b0;
                if (i2c_cmd.write) begin
                    write_ord = write_ord + 1;
                    // nack plan indexed by write ordinal
                    if (write_ord < 64) begin
                        give_nack = nack_set[write_ord];
                    end
                end
                wait_random_latency(4);
                // ack_err travels with done
                i2c_rsp.done    = 1'b1;
                i2c_rsp.ack_err = give_nack;
                @(posedge clk);
                #5;
                i2c_rsp = '0;
            end
        end
    end

endmodule

// File: tb_oled_init.sv
`include "oled_init_settings.svh"

module tb_oled_init;
    timeunit 1ns;
    timeprecision 1ps;

    import oled_init_pkg::*;

    localparam int settle_cycles = 20;
    // twice the delays plus 25 bytes of 6 cycles
    localparam int test_budget = 2 * (`OLED_POWER_ON_CYCLES + `OLED_GAP1_CYCLES
                                      + `OLED_GAP2_CYCLES + 25 * 6);

    logic         clk;
    logic         reset;
    logic         oled_granted;
    i2c_rsp_t     i2c_rsp;
    logic         oled_req;
    i2c_cmd_t     i2c_cmd;
    init_status_t status;
    logic [63:0]  nack_set;

    // one pattern file entry per test
    string        test_name [$];
    logic [63:0]  nack_plan [$];
    bit           want_ready [$];
    int           exp_base [$];
    int           exp_count [$];
    logic [11:0]  exp_words [$];
    bit           patterns_ready;

    // monitor state
    // words are 1xx for a start write, 0xx for a write and 200 for stop
    logic [11:0]  got_words [$];
    bit           mon_active;
    bit           prev_req;
    bit           gap_pending;
    int           cycle_cnt;
    int           first_req_cycle;
    int           stop_cycle;
    int           stops_seen;
    int           gaps_checked;
    int           total_errs;
    int           tests_failed;

    oled_init_top uut (
        .clk          (clk),
        .reset        (reset),
        .oled_granted (oled_granted),
        .i2c_rsp      (i2c_rsp),
        .oled_req     (oled_req),
        .i2c_cmd      (i2c_cmd),
        .status       (status)
    );

    tb_i2c_master_model u_master (
        .clk          (clk),
        .reset        (reset),
        .oled_req     (oled_req),
        .i2c_cmd      (i2c_cmd),
        .nack_set     (nack_set),
        .oled_granted (oled_granted),
        .i2c_rsp      (i2c_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, want);
        total_errs = total_errs + 1;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0d ns: %s", $time, what);
        total_errs = total_errs + 1;
    endtask

    // record finished commands and bus request timing
    always @(negedge clk) begin
        if (mon_active) begin
            cycle_cnt = cycle_cnt + 1;
            if (i2c_rsp.done && i2c_cmd.stop) begin
                got_words.push_back(12'h200);
                stops_seen  = stops_seen + 1;
                stop_cycle  = cycle_cnt;
                gap_pending = 1'b1;
            end else if (i2c_rsp.done && i2c_cmd.write) begin
                got_words.push_back({3'b000, i2c_cmd.start, i2c_cmd.data});
            end
            if (oled_req && !prev_req) begin
                if (first_req_cycle < 0) begin
                    first_req_cycle = cycle_cnt;
                    if (cycle_cnt < `OLED_POWER_ON_CYCLES) begin
                        report_failure($sformatf("bus request %0d cycles after reset, too early",
                                                 cycle_cnt));
                    end
                end
                if (gap_pending) begin
                    gap_pending  = 1'b0;
                    gaps_checked = gaps_checked + 1;
                    // gap1 follows the first stop and gap2 the second
                    if (stops_seen == 1 && cycle_cnt - stop_cycle < `OLED_GAP1_CYCLES) begin
                        report_failure("gap after phase 1 shorter than GAP1_CYCLES");
                    end
                    if (stops_seen == 2 && cycle_cnt - stop_cycle < `OLED_GAP2_CYCLES) begin
                        report_failure("gap after phase 2 shorter than GAP2_CYCLES");
                    end
                end
            end
            prev_req = oled_req;
        end
    end

    task automatic load_patterns();
        int          fd;
        int          code;
        int          n;
        int          ord;
        string       tok;
        string       line;
        logic [11:0] word;
        logic [63:0] mask;
        fd = $fopen("oled_init_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open oled_init_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            test_name.push_back(tok);
            // nack ordinals
            mask = '0;
            code = $fscanf(fd, "%d", n);
            repeat (n) begin
                code = $fscanf(fd, "%d", ord);
                if (ord >= 0 && ord < 64) begin
                    mask[ord] = 1'b1;
                end
            end
            nack_plan.push_back(mask);
            code = $fscanf(fd, "%s", tok);
            if (tok != "ready" && tok != "error") begin
                report_failure($sformatf("unknown outcome %s in pattern file", tok));
            end
            want_ready.push_back(tok == "ready");
            // expected command words
            code = $fscanf(fd, "%d", n);
            exp_base.push_back(exp_words.size());
            exp_count.push_back(n);
            repeat (n) begin
                code = $fscanf(fd, "%h", word);
                exp_words.push_back(word);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle_outputs();
        if (oled_req !== 1'b0) report_mismatch("oled_req", oled_req, 0);
        if (i2c_cmd.start !== 1'b0) report_mismatch("i2c_cmd.start", i2c_cmd.start, 0);
        if (i2c_cmd.stop !== 1'b0) report_mismatch("i2c_cmd.stop", i2c_cmd.stop, 0);
        if (i2c_cmd.write !== 1'b0) report_mismatch("i2c_cmd.write", i2c_cmd.write, 0);
        if (status.busy !== 1'b1) report_mismatch("status.busy", status.busy, 1);
        if (status.init_done !== 1'b0) report_mismatch("status.init_done", status.init_done, 0);
        if (status.err !== 1'b0) report_mismatch("status.err", status.err, 0);
    endtask

    task automatic run_test(input int t);
        int          errs_before;
        int          k;
        logic [11:0] want;
        errs_before = total_errs;
        @(posedge clk);
        #5;
        reset       = 1'b1;
        nack_set    = nack_plan[t];
        got_words.delete();
        prev_req        = 1'b0;
        gap_pending     = 1'b0;
        cycle_cnt       = 0;
        first_req_cycle = -1;
        stops_seen      = 0;
        gaps_checked    = 0;
        @(negedge clk);
        check_idle_outputs();
        // reset spans two full cycles, so the master sees it too
        @(posedge clk);
        @(posedge clk);
        #5;
        reset      = 1'b0;
        mon_active = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        // either flag ends the run
        while (!(status.init_done || status.err)) begin
            @(negedge clk);
        end
        // flags must hold and the bus must stay quiet
        repeat (settle_cycles) @(negedge clk);
        @(posedge clk);
        #5;
        mon_active = 1'b0;
        if (want_ready[t]) begin
            if (status.init_done !== 1'b1) report_mismatch("status.init_done", status.init_done, 1);
            if (status.err !== 1'b0) report_mismatch("status.err", status.err, 0);
        end else begin
            if (status.err !== 1'b1) report_mismatch("status.err", status.err, 1);
            if (status.init_done !== 1'b0) report_mismatch("status.init_done", status.init_done, 0);
        end
        if (status.busy !== 1'b0) report_mismatch("status.busy", status.busy, 0);
        if (oled_req !== 1'b0) report_mismatch("oled_req", oled_req, 0);
        if (i2c_cmd.write || i2c_cmd.stop) report_failure("command still pending at the end");
        if (first_req_cycle < 0) report_failure("no bus request seen");
        if (gaps_checked != stops_seen - (want_ready[t] ? 1 : 0)) begin
            report_failure("a phase was not followed by a measured gap");
        end
        if (got_words.size() != exp_count[t]) begin
            report_mismatch("command count", got_words.size(), exp_count[t]);
        end
        for (k = 0; k < exp_count[t] && k < got_words.size(); k++) begin
            want = exp_words[exp_base[t] + k];
            if (got_words[k] !== want) begin
                report_mismatch($sformatf("i2c_cmd[%0d]", k), got_words[k], want);
            end
        end
        if (total_errs != errs_before) tests_failed = tests_failed + 1;
        $display("test %s %s, %0d errors", test_name[t],
                 (total_errs == errs_before) ? "passed" : "FAILED", total_errs - errs_before);
    endtask

    // bounds the whole run
    initial begin
        wait (patterns_ready);
        repeat ((test_name.size() + 1) * test_budget) @(posedge clk);
        $display("watchdog expired, the DUT never finished a test");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int t;
        reset          = 1'b1;
        nack_set       = '0;
        mon_active     = 1'b0;
        patterns_ready = 1'b0;
        total_errs     = 0;
        tests_failed   = 0;
        load_patterns();
        if (test_name.size() == 0) begin
            report_failure("no tests found in the pattern file");
        end
        patterns_ready = 1'b1;
        for (t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", test_name.size(), tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: oled_init_patterns.txt
# name  nack_count  nack write ordinals  outcome  command_count
# then the commands as hex: 1xx write with start, 0xx write, 200 stop
# clean run, three phases
clean 0 ready 27
178 000 0a8 03f 0d3 000 040 0a1 0c8 0da 012 081 07f 0a4 0a6 0d5 080 200
178 000 08d 014 200
178 000 0af 200
# nack on write 8 restarts phase 1
retry 1 8 ready 35
178 000 0a8 03f 0d3 000 040 0a1
178 000 0a8 03f 0d3 000 040 0a1 0c8 0da 012 081 07f 0a4 0a6 0d5 080 200
178 000 08d 014 200
178 000 0af 200
# four nacks on the phase 2 address
error 4 18 19 20 21 error 22
178 000 0a8 03f 0d3 000 040 0a1 0c8 0da 012 081 07f 0a4 0a6 0d5 080 200
178 178 178 178
# three nacks then an ack
recover 3 18 19 20 ready 30
178 000 0a8 03f 0d3 000 040 0a1 0c8 0da 012 081 07f 0a4 0a6 0d5 080 200
178 178 178
178 000 08d 014 200
178 000 0af 200

// File: compile.f
+incdir+.
oled_init_pkg.sv
init_cmd_rom.sv
init_delay_timer.sv
i2c_txn_sequencer.sv
init_phase_ctrl.sv
oled_init_top.sv
tb_i2c_master_model.sv
tb_oled_init.sv
